// File: include/udp_echo_defines.svh
// ##########################################################################
// Field widths, echo port and FIFO depth for the UDP echo core.
// Included by the packages and by any module that sizes logic from them.
// ##########################################################################

`ifndef UDP_ECHO_DEFINES_SVH
`define UDP_ECHO_DEFINES_SVH

// IPv4 address width
`define UDP_ECHO_IP_ADDR_W 32

// UDP port and UDP length width
`define UDP_ECHO_PORT_W 16

// Payload is carried one byte per beat
`define UDP_ECHO_DATA_W 8

// Frames sent to this port are echoed, all others are dropped
`define UDP_ECHO_PORT 1234

// Payload FIFO entries
`define UDP_ECHO_FIFO_DEPTH 16

`endif

// File: rtl/net_field_pkg.sv
// ##########################################################################
// Types for the parsed UDP and IP header fields used by the echo core.
// ##########################################################################

`default_nettype none

`include "udp_echo_defines.svh"

package net_field_pkg;

    // IPv4 address, network byte order as one word
    typedef logic [`UDP_ECHO_IP_ADDR_W-1:0] ip_addr_t;

    // UDP source or destination port
    typedef logic [`UDP_ECHO_PORT_W-1:0] udp_port_t;

    // UDP length field, header plus payload in bytes
    typedef logic [`UDP_ECHO_PORT_W-1:0] udp_len_t;

endpackage

`default_nettype wire

// File: rtl/payload_pkg.sv
// ##########################################################################
// Types for the byte-wide payload stream and its per-beat flags.
// ##########################################################################

`default_nettype none

`include "udp_echo_defines.svh"

package payload_pkg;

    // One payload byte
    typedef logic [`UDP_ECHO_DATA_W-1:0] payload_data_t;

    // Bad-frame flag travelling with each beat
    typedef logic payload_user_t;

endpackage

`default_nettype wire

// File: rtl/payload_fifo.sv
// ##########################################################################
// First-word-fall-through FIFO for payload bytes with last and user flags.
// The head entry is presented on rd_* whenever rd_valid is high.
// ##########################################################################

`default_nettype none

`include "udp_echo_defines.svh"

module payload_fifo
    import payload_pkg::*;
#(
    parameter int DEPTH = `UDP_ECHO_FIFO_DEPTH
) (
    input  logic          clk,
    input  logic          rst,

    // Write side
    input  payload_data_t wr_data,
    input  logic          wr_last,
    input  payload_user_t wr_user,
    input  logic          wr_valid,
    output logic          wr_ready,

    // Read side
    output payload_data_t rd_data,
    output logic          rd_last,
    output payload_user_t rd_user,
    output logic          rd_valid,
    input  logic          rd_ready
);

    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int ENTRY_W = $bits(payload_data_t) + 1 + $bits(payload_user_t);

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_fire;
    logic               rd_fire;

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    assign {rd_user, rd_last, rd_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= {wr_user, wr_last, wr_data};
        end
    end

    // Pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_fire) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/udp_echo_steer.sv
// ##########################################################################
// Decides per frame whether to echo or drop, builds the reply header and
// routes the payload of echoed frames into the payload FIFO.
// ##########################################################################

`default_nettype none

`include "udp_echo_defines.svh"

module udp_echo_steer
    import net_field_pkg::*, payload_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    // Parsed input header
    input  logic          in_hdr_valid,
    output logic          in_hdr_ready,
    input  ip_addr_t      in_hdr_src_ip,
    input  udp_port_t     in_hdr_src_port,
    input  udp_port_t     in_hdr_dest_port,
    input  udp_len_t      in_hdr_length,

    // Reply header
    output logic          reply_hdr_valid,
    input  logic          reply_hdr_ready,
    output ip_addr_t      reply_hdr_dest_ip,
    output udp_port_t     reply_hdr_src_port,
    output udp_port_t     reply_hdr_dest_port,
    output udp_len_t      reply_hdr_length,

    // Input payload
    input  payload_data_t in_payload_data,
    input  logic          in_payload_last,
    input  payload_user_t in_payload_user,
    input  logic          in_payload_valid,
    output logic          in_payload_ready,

    // FIFO write side
    output payload_data_t wr_data,
    output logic          wr_last,
    output payload_user_t wr_user,
    output logic          wr_valid,
    input  logic          wr_ready
);

    logic echo_match;
    logic busy;
    logic echo;
    logic hdr_fire;
    logic last_fire;

    assign echo_match = (in_hdr_dest_port == udp_port_t'(`UDP_ECHO_PORT));

    // An echo header waits until the reply header can leave with it
    assign in_hdr_ready    = !busy && (!echo_match || reply_hdr_ready);
    assign reply_hdr_valid = !busy && in_hdr_valid && echo_match;

    // Reply goes back to the sender with the ports swapped
    assign reply_hdr_dest_ip   = in_hdr_src_ip;
    assign reply_hdr_src_port  = in_hdr_dest_port;
    assign reply_hdr_dest_port = in_hdr_src_port;
    assign reply_hdr_length    = in_hdr_length;

    // Dropped frames are swallowed at full rate
    assign in_payload_ready = busy && (!echo || wr_ready);

    assign wr_data  = in_payload_data;
    assign wr_last  = in_payload_last;
    assign wr_user  = in_payload_user;
    assign wr_valid = busy && echo && in_payload_valid;

    assign hdr_fire  = in_hdr_valid && in_hdr_ready;
    assign last_fire = in_payload_valid && in_payload_ready && in_payload_last;

    // Decision is latched at the header and held to the end of the payload
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            echo <= 1'b0;
        end else if (!busy) begin
            if (hdr_fire) begin
                busy <= 1'b1;
                echo <= echo_match;
            end
        end else if (last_fire) begin
            busy <= 1'b0;
            echo <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/first_byte_led.sv
// ##########################################################################
// Shows the first byte of each outgoing payload frame on the LEDs.
// ##########################################################################

`default_nettype none

module first_byte_led
    import payload_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  payload_data_t data,
    input  logic          last,
    input  logic          valid,
    input  logic          ready,
    output payload_data_t led
);

    logic in_frame;
    logic fire;

    assign fire = valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (fire) begin
            if (!in_frame) begin
                led <= data;
            end
            // Rearm on the closing beat
            in_frame <= !last;
        end
    end

endmodule

`default_nettype wire

// File: rtl/udp_echo_top.sv
// ##########################################################################
// UDP echo core. Takes parsed UDP frames, answers those sent to the echo
// port with a swapped header and the buffered payload, drops the rest.
// ##########################################################################

`default_nettype none

`include "udp_echo_defines.svh"

module udp_echo_top
    import net_field_pkg::*, payload_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    // Parsed input header
    input  logic          in_hdr_valid,
    output logic          in_hdr_ready,
    input  ip_addr_t      in_hdr_src_ip,
    input  udp_port_t     in_hdr_src_port,
    input  udp_port_t     in_hdr_dest_port,
    input  udp_len_t      in_hdr_length,

    // Reply header
    output logic          reply_hdr_valid,
    input  logic          reply_hdr_ready,
    output ip_addr_t      reply_hdr_dest_ip,
    output udp_port_t     reply_hdr_src_port,
    output udp_port_t     reply_hdr_dest_port,
    output udp_len_t      reply_hdr_length,

    // Input payload
    input  payload_data_t in_payload_data,
    input  logic          in_payload_last,
    input  payload_user_t in_payload_user,
    input  logic          in_payload_valid,
    output logic          in_payload_ready,

    // Echoed payload
    output payload_data_t out_payload_data,
    output logic          out_payload_last,
    output payload_user_t out_payload_user,
    output logic          out_payload_valid,
    input  logic          out_payload_ready,

    output payload_data_t led
);

    // Steer to FIFO
    payload_data_t echo_data;
    logic          echo_last;
    payload_user_t echo_user;
    logic          echo_valid;
    logic          echo_ready;

    udp_echo_steer i_steer (
        .clk                 (clk),
        .rst                 (rst),
        .in_hdr_valid        (in_hdr_valid),
        .in_hdr_ready        (in_hdr_ready),
        .in_hdr_src_ip       (in_hdr_src_ip),
        .in_hdr_src_port     (in_hdr_src_port),
        .in_hdr_dest_port    (in_hdr_dest_port),
        .in_hdr_length       (in_hdr_length),
        .reply_hdr_valid     (reply_hdr_valid),
        .reply_hdr_ready     (reply_hdr_ready),
        .reply_hdr_dest_ip   (reply_hdr_dest_ip),
        .reply_hdr_src_port  (reply_hdr_src_port),
        .reply_hdr_dest_port (reply_hdr_dest_port),
        .reply_hdr_length    (reply_hdr_length),
        .in_payload_data     (in_payload_data),
        .in_payload_last     (in_payload_last),
        .in_payload_user     (in_payload_user),
        .in_payload_valid    (in_payload_valid),
        .in_payload_ready    (in_payload_ready),
        .wr_data             (echo_data),
        .wr_last             (echo_last),
        .wr_user             (echo_user),
        .wr_valid            (echo_valid),
        .wr_ready            (echo_ready)
    );

    payload_fifo #(
        .DEPTH (`UDP_ECHO_FIFO_DEPTH)
    ) i_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (echo_data),
        .wr_last  (echo_last),
        .wr_user  (echo_user),
        .wr_valid (echo_valid),
        .wr_ready (echo_ready),
        .rd_data  (out_payload_data),
        .rd_last  (out_payload_last),
        .rd_user  (out_payload_user),
        .rd_valid (out_payload_valid),
        .rd_ready (out_payload_ready)
    );

    first_byte_led i_led (
        .clk   (clk),
        .rst   (rst),
        .data  (out_payload_data),
        .last  (out_payload_last),
        .valid (out_payload_valid),
        .ready (out_payload_ready),
        .led   (led)
    );

endmodule

`default_nettype wire

// File: test/tb_udp_echo.sv
// ##########################################################################
// Testbench for the UDP echo core. Sends random echo and non-echo frames
// and checks reply headers, echoed payload and the LED byte against a model.
// ##########################################################################

`default_nettype none

`include "udp_echo_defines.svh"

module tb_udp_echo
    import net_field_pkg::*, payload_pkg::*;
();

    localparam logic [31:0] SEED = 32'h1119;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic          clk;
    logic          rst;
    logic          in_hdr_valid;
    logic          in_hdr_ready;
    ip_addr_t      in_hdr_src_ip;
    udp_port_t     in_hdr_src_port;
    udp_port_t     in_hdr_dest_port;
    udp_len_t      in_hdr_length;
    logic          reply_hdr_valid;
    logic          reply_hdr_ready;
    ip_addr_t      reply_hdr_dest_ip;
    udp_port_t     reply_hdr_src_port;
    udp_port_t     reply_hdr_dest_port;
    udp_len_t      reply_hdr_length;
    payload_data_t in_payload_data;
    logic          in_payload_last;
    payload_user_t in_payload_user;
    logic          in_payload_valid;
    logic          in_payload_ready;
    payload_data_t out_payload_data;
    logic          out_payload_last;
    payload_user_t out_payload_user;
    logic          out_payload_valid;
    logic          out_payload_ready;
    payload_data_t led;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_mark = 0;
    int stall_left = 0;
    int stall_seen = 0;
    logic [31:0] stim_state = SEED;

    // Payload of the frame being sent
    payload_data_t frame_data [64];
    payload_user_t frame_user [64];

    // Expected results in arrival order
    ip_addr_t      exp_ip [$];
    udp_port_t     exp_sport [$];
    udp_port_t     exp_dport [$];
    udp_len_t      exp_len [$];
    payload_data_t exp_data [$];
    logic          exp_last [$];
    payload_user_t exp_user [$];
    payload_data_t exp_led [$];

    udp_echo_top i_dut (.*);

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic udp_port_t other_port();
        udp_port_t p;
        p = udp_port_t'(rand_next());
        if (p == udp_port_t'(`UDP_ECHO_PORT)) p = p + 16'd1;
        return p;
    endfunction

    // Random payload length of 1 to 20 bytes
    function automatic int frame_length();
        return 1 + int'(rand_next() % 20);
    endfunction

    // Model of the echo core that queues the reply header and beats of echoed frames
    function automatic void expect_frame(udp_port_t dport, ip_addr_t ip, udp_port_t sport,
                                         udp_len_t len, int nbytes);
        int i;
        if (dport != udp_port_t'(`UDP_ECHO_PORT)) return;
        exp_ip.push_back(ip);
        exp_sport.push_back(dport);
        exp_dport.push_back(sport);
        exp_len.push_back(len);
        exp_led.push_back(frame_data[0]);
        for (i = 0; i < nbytes; i++) begin
            exp_data.push_back(frame_data[i]);
            exp_user.push_back(frame_user[i]);
            exp_last.push_back(i == nbytes - 1);
        end
    endfunction

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_error(string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic abort_run(string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic check_header(ip_addr_t got_ip, ip_addr_t e_ip, udp_port_t got_sp,
                                udp_port_t e_sp, udp_port_t got_dp, udp_port_t e_dp,
                                udp_len_t got_len, udp_len_t e_len);
        checks++;
        if (got_ip !== e_ip) mismatch("reply_hdr_dest_ip", got_ip, e_ip);
        if (got_sp !== e_sp) mismatch("reply_hdr_src_port", 32'(got_sp), 32'(e_sp));
        if (got_dp !== e_dp) mismatch("reply_hdr_dest_port", 32'(got_dp), 32'(e_dp));
        if (got_len !== e_len) mismatch("reply_hdr_length", 32'(got_len), 32'(e_len));
    endtask

    task automatic check_beat(payload_data_t got_data, payload_data_t e_data, logic got_last,
                              logic e_last, payload_user_t got_user, payload_user_t e_user);
        checks++;
        if (got_data !== e_data) mismatch("out_payload_data", 32'(got_data), 32'(e_data));
        if (got_last !== e_last) mismatch("out_payload_last", 32'(got_last), 32'(e_last));
        if (got_user !== e_user) mismatch("out_payload_user", 32'(got_user), 32'(e_user));
    endtask

    task automatic check_led(payload_data_t got, payload_data_t e_led);
        checks++;
        if (got !== e_led) mismatch("led", 32'(got), 32'(e_led));
    endtask

    // Sends the header and then the payload beats with random idle gaps
    task automatic send_frame(udp_port_t dport, int nbytes);
        logic [31:0] r;
        logic echo;
        int i;
        int n;
        echo = (dport == udp_port_t'(`UDP_ECHO_PORT));
        @(negedge clk);
        in_hdr_src_ip = rand_next();
        in_hdr_src_port = udp_port_t'(rand_next());
        in_hdr_dest_port = dport;
        in_hdr_length = udp_len_t'(8 + nbytes);
        for (i = 0; i < nbytes; i++) begin
            r = rand_next();
            frame_data[i] = r[7:0];
            frame_user[i] = r[8];
        end
        expect_frame(dport, in_hdr_src_ip, in_hdr_src_port, in_hdr_length, nbytes);
        in_hdr_valid = 1'b1;
        n = 0;
        @(posedge clk);
        while (!in_hdr_ready) begin
            if (!echo) report_error("in_hdr_ready low for a discard header while idle");
            n++;
            if (n > ACCEPT_TIMEOUT) abort_run("input header was never accepted");
            @(posedge clk);
        end
        @(negedge clk);
        in_hdr_valid = 1'b0;
        for (i = 0; i < nbytes; i++) begin
            if (rand_next() % 4 == 0) begin
                in_payload_valid = 1'b0;
                @(negedge clk);
            end
            in_payload_valid = 1'b1;
            in_payload_data = frame_data[i];
            in_payload_user = frame_user[i];
            in_payload_last = (i == nbytes - 1);
            n = 0;
            @(posedge clk);
            if (in_hdr_ready) report_error("in_hdr_ready high while a frame is in progress");
            while (!in_payload_ready) begin
                if (!echo) report_error("in_payload_ready went low while discarding");
                else stall_seen++;
                n++;
                if (n > ACCEPT_TIMEOUT) abort_run("payload beat was never accepted");
                @(posedge clk);
            end
            @(negedge clk);
        end
        in_payload_valid = 1'b0;
        in_payload_last = 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_data.size() != 0 || exp_ip.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > DRAIN_TIMEOUT) abort_run("expected output never drained");
        end
        // Let the monitor finish its pending LED check
        repeat (2) @(negedge clk);
    endtask

    task automatic finish_test(string name, int frames);
        tests_run++;
        if (errors != test_mark) begin
            tests_failed++;
            $display("Test %-13s %3d frames, failed with %0d errors", name, frames,
                     errors - test_mark);
        end else begin
            $display("Test %-13s %3d frames, ok", name, frames);
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Output side ready levels and forced stalls for the FIFO fill test
    initial begin : ready_drive
        logic [31:0] r;
        r = SEED ^ 32'h5a5a_0f0f;
        reply_hdr_ready = 1'b0;
        out_payload_ready = 1'b0;
        forever begin
            @(negedge clk);
            r = xorshift32(r);
            reply_hdr_ready = r[3] | r[9];
            if (stall_left > 0) begin
                out_payload_ready = 1'b0;
                stall_left--;
            end else begin
                out_payload_ready = r[5] | r[12];
            end
        end
    end

    initial begin : monitor
        payload_data_t led_exp;
        logic led_pending;
        logic last_exp;
        led_pending = 1'b0;
        forever begin
            @(posedge clk);
            if (led_pending) begin
                check_led(led, led_exp);
                led_pending = 1'b0;
            end
            if (!rst && reply_hdr_valid && reply_hdr_ready) begin
                if (exp_ip.size() == 0) begin
                    report_error("reply header sent for a frame that was not echoed");
                end else begin
                    check_header(reply_hdr_dest_ip, exp_ip.pop_front(), reply_hdr_src_port,
                                 exp_sport.pop_front(), reply_hdr_dest_port,
                                 exp_dport.pop_front(), reply_hdr_length, exp_len.pop_front());
                end
            end
            if (!rst && out_payload_valid && out_payload_ready) begin
                if (exp_data.size() == 0) begin
                    report_error("output beat appeared with no echoed byte expected");
                end else begin
                    last_exp = exp_last.pop_front();
                    check_beat(out_payload_data, exp_data.pop_front(), out_payload_last,
                               last_exp, out_payload_user, exp_user.pop_front());
                    if (last_exp) begin
                        led_exp = exp_led.pop_front();
                        led_pending = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : main
        int i;
        rst = 1'b1;
        in_hdr_valid = 1'b0;
        in_hdr_src_ip = '0;
        in_hdr_src_port = '0;
        in_hdr_dest_port = '0;
        in_hdr_length = '0;
        in_payload_data = '0;
        in_payload_last = 1'b0;
        in_payload_user = '0;
        in_payload_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_mark = errors;
        checks += 2;
        if (reply_hdr_valid !== 1'b0) report_error("reply_hdr_valid is not low after reset");
        if (out_payload_valid !== 1'b0) report_error("out_payload_valid is not low after reset");
        check_led(led, '0);
        finish_test("reset", 0);

        test_mark = errors;
        for (i = 0; i < 12; i++) send_frame(udp_port_t'(`UDP_ECHO_PORT), frame_length());
        wait_drained();
        finish_test("echo", 12);

        test_mark = errors;
        for (i = 0; i < 12; i++) send_frame(other_port(), frame_length());
        wait_drained();
        finish_test("discard", 12);

        test_mark = errors;
        for (i = 0; i < 30; i++) begin
            if (rand_next() % 2 == 0) send_frame(udp_port_t'(`UDP_ECHO_PORT), frame_length());
            else send_frame(other_port(), frame_length());
        end
        wait_drained();
        finish_test("mixed", 30);

        // Frames longer than the FIFO behind a long output stall
        test_mark = errors;
        stall_seen = 0;
        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            stall_left = 60;
            send_frame(udp_port_t'(`UDP_ECHO_PORT),
                       `UDP_ECHO_FIFO_DEPTH + 8 + int'(rand_next() % 16));
        end
        wait_drained();
        checks++;
        if (stall_seen == 0) report_error("input payload was never stalled by a full FIFO");
        finish_test("backpressure", 3);

        $display("Tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
rtl/net_field_pkg.sv
rtl/payload_pkg.sv
rtl/payload_fifo.sv
rtl/udp_echo_steer.sv
rtl/first_byte_led.sv
rtl/udp_echo_top.sv
test/tb_udp_echo.sv

// File: Makefile
# Verilator build and run for the UDP echo core

VERILATOR  ?= verilator
TB_TOP     ?= tb_udp_echo
RTL_TOP    ?= udp_echo_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard rtl/*.sv test/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q -x "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
